/* hdl/ext_device_pkg.sv */
// Shared bus widths, register offsets and copy engine states for the external device subsystem
// Modules refer to these by scoped name

package ext_device_pkg;

  // Bus widths
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned BE_W = 4;

  // Low address bits used for register decode
  localparam int unsigned REG_OFF_W = 8;

  typedef enum logic [REG_OFF_W-1:0] {
    REG_SRC    = 8'h00,
    REG_DST    = 8'h04,
    REG_SIZE   = 8'h08,
    REG_START  = 8'h0C,
    REG_STATUS = 8'h10
  } reg_offset_e;

  // STATUS bit positions
  localparam int unsigned STATUS_DONE_BIT = 0;
  localparam int unsigned STATUS_BUSY_BIT = 1;

  typedef enum logic [2:0] {
    IDLE,
    RD_REQ,
    RD_WAIT,
    WR_REQ,
    WR_WAIT,
    DONE
  } copy_state_e;

endpackage

/* hdl/ext_device_top.sv */
// External device subsystem top level
// Memory-copy peripheral and outside master share the slow RAM through the arbiter

`timescale 1ns/1ps

module ext_device_top #(
  parameter int unsigned NUM_WORDS = 128,
  parameter int unsigned CNT_MAX   = 2048
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Register port
  input  logic                                reg_req_i,
  input  logic                                reg_we_i,
  input  logic [ext_device_pkg::ADDR_W-1:0]   reg_addr_i,
  input  logic [ext_device_pkg::DATA_W-1:0]   reg_wdata_i,
  output logic [ext_device_pkg::DATA_W-1:0]   reg_rdata_o,
  output logic                                reg_ready_o,
  output logic                                reg_error_o,
  // Outside OBI master
  input  logic                                ext_req_i,
  input  logic                                ext_we_i,
  input  logic [ext_device_pkg::ADDR_W-1:0]   ext_addr_i,
  input  logic [ext_device_pkg::DATA_W-1:0]   ext_wdata_i,
  input  logic [ext_device_pkg::BE_W-1:0]     ext_be_i,
  output logic                                ext_gnt_o,
  output logic                                ext_rvalid_o,
  output logic [ext_device_pkg::DATA_W-1:0]   ext_rdata_o,
  // Interrupt and GPIO
  output logic                                memcopy_intr_o,
  input  logic                                gpio_i,
  output logic                                gpio_o
);

  localparam int unsigned MEM_AW = $clog2(NUM_WORDS);

  // Register file to engine
  logic [ext_device_pkg::ADDR_W-1:0] copy_src;
  logic [ext_device_pkg::ADDR_W-1:0] copy_dst;
  logic [ext_device_pkg::DATA_W-1:0] copy_size;
  logic                              copy_start;
  logic                              copy_finish;
  ext_device_pkg::copy_state_e       copy_state;

  // Engine master port
  logic                              eng_req;
  logic                              eng_we;
  logic [ext_device_pkg::ADDR_W-1:0] eng_addr;
  logic [ext_device_pkg::DATA_W-1:0] eng_wdata;
  logic [ext_device_pkg::BE_W-1:0]   eng_be;
  logic                              eng_gnt;
  logic                              eng_rvalid;
  logic [ext_device_pkg::DATA_W-1:0] eng_rdata;

  // Arbiter to RAM
  logic                              mem_req;
  logic                              mem_we;
  logic [ext_device_pkg::ADDR_W-1:0] mem_addr;
  logic [ext_device_pkg::DATA_W-1:0] mem_wdata;
  logic [ext_device_pkg::BE_W-1:0]   mem_be;
  logic                              mem_gnt;
  logic                              mem_rvalid;
  logic [ext_device_pkg::DATA_W-1:0] mem_rdata;

  memcopy_regs u_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_req_i   (reg_req_i),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_ready_o (reg_ready_o),
    .reg_error_o (reg_error_o),
    .src_o       (copy_src),
    .dst_o       (copy_dst),
    .size_o      (copy_size),
    .start_o     (copy_start),
    .state_i     (copy_state),
    .finish_i    (copy_finish),
    .intr_o      (memcopy_intr_o)
  );

  memcopy_engine u_engine (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .src_i      (copy_src),
    .dst_i      (copy_dst),
    .size_i     (copy_size),
    .start_i    (copy_start),
    .state_o    (copy_state),
    .finish_o   (copy_finish),
    .m_req_o    (eng_req),
    .m_we_o     (eng_we),
    .m_addr_o   (eng_addr),
    .m_wdata_o  (eng_wdata),
    .m_be_o     (eng_be),
    .m_gnt_i    (eng_gnt),
    .m_rvalid_i (eng_rvalid),
    .m_rdata_i  (eng_rdata)
  );

  // Outside master is 0, copy engine is 1
  obi_arbiter u_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .m0_req_i    (ext_req_i),
    .m0_we_i     (ext_we_i),
    .m0_addr_i   (ext_addr_i),
    .m0_wdata_i  (ext_wdata_i),
    .m0_be_i     (ext_be_i),
    .m0_gnt_o    (ext_gnt_o),
    .m0_rvalid_o (ext_rvalid_o),
    .m0_rdata_o  (ext_rdata_o),
    .m1_req_i    (eng_req),
    .m1_we_i     (eng_we),
    .m1_addr_i   (eng_addr),
    .m1_wdata_i  (eng_wdata),
    .m1_be_i     (eng_be),
    .m1_gnt_o    (eng_gnt),
    .m1_rvalid_o (eng_rvalid),
    .m1_rdata_o  (eng_rdata),
    .s_req_o     (mem_req),
    .s_we_o      (mem_we),
    .s_addr_o    (mem_addr),
    .s_wdata_o   (mem_wdata),
    .s_be_o      (mem_be),
    .s_gnt_i     (mem_gnt),
    .s_rvalid_i  (mem_rvalid),
    .s_rdata_i   (mem_rdata)
  );

  slow_memory #(
    .NUM_WORDS (NUM_WORDS)
  ) u_slow_ram (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (mem_req),
    .we_i     (mem_we),
    .addr_i   (mem_addr[MEM_AW+1:2]),
    .wdata_i  (mem_wdata),
    .be_i     (mem_be),
    .gnt_o    (mem_gnt),
    .rvalid_o (mem_rvalid),
    .rdata_o  (mem_rdata)
  );

  gpio_cnt #(
    .CNT_MAX (CNT_MAX)
  ) u_gpio_cnt (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .gpio_i  (gpio_i),
    .gpio_o  (gpio_o)
  );

endmodule

/* hdl/gpio_cnt.sv */
// GPIO edge counter
// Toggles gpio_o each time CNT_MAX rising edges have been seen on gpio_i

`timescale 1ns/1ps

module gpio_cnt #(
  parameter int unsigned CNT_MAX = 2048
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic gpio_i,
  output logic gpio_o
);

  logic [2:0]                       sync_q;
  logic                             rise;
  logic [$clog2(CNT_MAX+1)-1:0]     cnt_q;
  logic                             out_q;

  // Two sync stages, the third flop keeps the previous level
  assign rise = sync_q[1] & ~sync_q[2];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
      cnt_q  <= '0;
      out_q  <= 1'b0;
    end else begin
      sync_q <= {sync_q[1:0], gpio_i};
      if (rise) begin
        if (cnt_q == ($clog2(CNT_MAX+1))'(CNT_MAX - 1)) begin
          cnt_q <= '0;
          out_q <= ~out_q;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  assign gpio_o = out_q;

endmodule

/* hdl/memcopy_engine.sv */
// Copy engine of the memory-copy peripheral
// Moves one word at a time from src to dst over an OBI master port

`timescale 1ns/1ps

module memcopy_engine (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // From and to the register file
  input  logic [ext_device_pkg::ADDR_W-1:0]   src_i,
  input  logic [ext_device_pkg::ADDR_W-1:0]   dst_i,
  input  logic [ext_device_pkg::DATA_W-1:0]   size_i,
  input  logic                                start_i,
  output ext_device_pkg::copy_state_e         state_o,
  output logic                                finish_o,
  // OBI master
  output logic                                m_req_o,
  output logic                                m_we_o,
  output logic [ext_device_pkg::ADDR_W-1:0]   m_addr_o,
  output logic [ext_device_pkg::DATA_W-1:0]   m_wdata_o,
  output logic [ext_device_pkg::BE_W-1:0]     m_be_o,
  input  logic                                m_gnt_i,
  input  logic                                m_rvalid_i,
  input  logic [ext_device_pkg::DATA_W-1:0]   m_rdata_i
);

  ext_device_pkg::copy_state_e state_q;
  ext_device_pkg::copy_state_e state_d;

  logic [ext_device_pkg::ADDR_W-1:0] src_q;
  logic [ext_device_pkg::ADDR_W-1:0] dst_q;
  logic [ext_device_pkg::DATA_W-1:0] cnt_q;
  logic [ext_device_pkg::DATA_W-1:0] data_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ext_device_pkg::IDLE: begin
        if (start_i) begin
          state_d = (size_i == '0) ? ext_device_pkg::DONE : ext_device_pkg::RD_REQ;
        end
      end
      ext_device_pkg::RD_REQ: begin
        if (m_gnt_i) begin
          state_d = ext_device_pkg::RD_WAIT;
        end
      end
      ext_device_pkg::RD_WAIT: begin
        if (m_rvalid_i) begin
          state_d = ext_device_pkg::WR_REQ;
        end
      end
      ext_device_pkg::WR_REQ: begin
        if (m_gnt_i) begin
          state_d = ext_device_pkg::WR_WAIT;
        end
      end
      ext_device_pkg::WR_WAIT: begin
        if (m_rvalid_i) begin
          // Last word written
          if (cnt_q == ext_device_pkg::DATA_W'(1)) begin
            state_d = ext_device_pkg::DONE;
          end else begin
            state_d = ext_device_pkg::RD_REQ;
          end
        end
      end
      default: state_d = ext_device_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ext_device_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Pointers, count and data buffer
  always_ff @(posedge clk_i) begin
    if (state_q == ext_device_pkg::IDLE && start_i) begin
      src_q <= src_i;
      dst_q <= dst_i;
      cnt_q <= size_i;
    end
    if (state_q == ext_device_pkg::RD_WAIT && m_rvalid_i) begin
      data_q <= m_rdata_i;
    end
    if (state_q == ext_device_pkg::WR_WAIT && m_rvalid_i) begin
      src_q <= src_q + ext_device_pkg::ADDR_W'(4);
      dst_q <= dst_q + ext_device_pkg::ADDR_W'(4);
      cnt_q <= cnt_q - ext_device_pkg::DATA_W'(1);
    end
  end

  // Bus outputs follow the registered state
  assign m_req_o   = (state_q == ext_device_pkg::RD_REQ) | (state_q == ext_device_pkg::WR_REQ);
  assign m_we_o    = (state_q == ext_device_pkg::WR_REQ);
  assign m_addr_o  = (state_q == ext_device_pkg::WR_REQ) ? dst_q : src_q;
  assign m_wdata_o = data_q;
  assign m_be_o    = '1;

  assign state_o  = state_q;
  assign finish_o = (state_q == ext_device_pkg::DONE);

endmodule

/* hdl/memcopy_regs.sv */
// Register file of the memory-copy peripheral
// Decodes the register port, holds the copy pointers and raises the completion interrupt

`timescale 1ns/1ps

module memcopy_regs (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Register port
  input  logic                                reg_req_i,
  input  logic                                reg_we_i,
  input  logic [ext_device_pkg::ADDR_W-1:0]   reg_addr_i,
  input  logic [ext_device_pkg::DATA_W-1:0]   reg_wdata_i,
  output logic [ext_device_pkg::DATA_W-1:0]   reg_rdata_o,
  output logic                                reg_ready_o,
  output logic                                reg_error_o,
  // Engine side
  output logic [ext_device_pkg::ADDR_W-1:0]   src_o,
  output logic [ext_device_pkg::ADDR_W-1:0]   dst_o,
  output logic [ext_device_pkg::DATA_W-1:0]   size_o,
  output logic                                start_o,
  input  ext_device_pkg::copy_state_e         state_i,
  input  logic                                finish_i,
  output logic                                intr_o
);

  logic [ext_device_pkg::ADDR_W-1:0] src_q;
  logic [ext_device_pkg::ADDR_W-1:0] dst_q;
  logic [ext_device_pkg::DATA_W-1:0] size_q;
  logic                              start_q;
  logic                              done_q;
  logic                              busy;
  logic                              addr_ok;
  logic [ext_device_pkg::REG_OFF_W-1:0] offset;
  logic                              wr_en;
  logic                              status_rd;

  assign offset  = reg_addr_i[ext_device_pkg::REG_OFF_W-1:0];
  assign addr_ok = (reg_addr_i[ext_device_pkg::ADDR_W-1:ext_device_pkg::REG_OFF_W] == '0);
  assign wr_en   = reg_req_i & reg_we_i & addr_ok;

  // A start still on its way to the engine counts as busy
  assign busy = (state_i != ext_device_pkg::IDLE) | start_q;

  assign status_rd = reg_req_i & ~reg_we_i & addr_ok & (offset == ext_device_pkg::REG_STATUS);

  // Zero-wait port
  assign reg_ready_o = reg_req_i;

  always_comb begin
    reg_rdata_o = '0;
    reg_error_o = 1'b0;
    if (reg_req_i) begin
      if (!addr_ok) begin
        reg_error_o = 1'b1;
      end else begin
        case (offset)
          ext_device_pkg::REG_SRC:    reg_rdata_o = src_q;
          ext_device_pkg::REG_DST:    reg_rdata_o = dst_q;
          ext_device_pkg::REG_SIZE:   reg_rdata_o = size_q;
          ext_device_pkg::REG_START:  reg_rdata_o = '0;
          ext_device_pkg::REG_STATUS: begin
            reg_rdata_o[ext_device_pkg::STATUS_DONE_BIT] = done_q;
            reg_rdata_o[ext_device_pkg::STATUS_BUSY_BIT] = busy;
          end
          default:                    reg_error_o = 1'b1;
        endcase
        if (reg_we_i) begin
          reg_rdata_o = '0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      src_q   <= '0;
      dst_q   <= '0;
      size_q  <= '0;
      start_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      start_q <= wr_en & (offset == ext_device_pkg::REG_START) & ~busy;
      if (wr_en && offset == ext_device_pkg::REG_SRC) begin
        src_q <= reg_wdata_i;
      end
      if (wr_en && offset == ext_device_pkg::REG_DST) begin
        dst_q <= reg_wdata_i;
      end
      if (wr_en && offset == ext_device_pkg::REG_SIZE) begin
        size_q <= reg_wdata_i;
      end
      // A finish in the same cycle as the read wins
      if (finish_i) begin
        done_q <= 1'b1;
      end else if (status_rd) begin
        done_q <= 1'b0;
      end
    end
  end

  assign src_o   = src_q;
  assign dst_o   = dst_q;
  assign size_o  = size_q;
  assign start_o = start_q;
  assign intr_o  = done_q;

endmodule

/* hdl/obi_arbiter.sv */
// Two-master OBI arbiter with round-robin priority
// Remembers the owner of each grant and routes the response back to it

`timescale 1ns/1ps

module obi_arbiter (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Master 0
  input  logic                                m0_req_i,
  input  logic                                m0_we_i,
  input  logic [ext_device_pkg::ADDR_W-1:0]   m0_addr_i,
  input  logic [ext_device_pkg::DATA_W-1:0]   m0_wdata_i,
  input  logic [ext_device_pkg::BE_W-1:0]     m0_be_i,
  output logic                                m0_gnt_o,
  output logic                                m0_rvalid_o,
  output logic [ext_device_pkg::DATA_W-1:0]   m0_rdata_o,
  // Master 1
  input  logic                                m1_req_i,
  input  logic                                m1_we_i,
  input  logic [ext_device_pkg::ADDR_W-1:0]   m1_addr_i,
  input  logic [ext_device_pkg::DATA_W-1:0]   m1_wdata_i,
  input  logic [ext_device_pkg::BE_W-1:0]     m1_be_i,
  output logic                                m1_gnt_o,
  output logic                                m1_rvalid_o,
  output logic [ext_device_pkg::DATA_W-1:0]   m1_rdata_o,
  // Slave side
  output logic                                s_req_o,
  output logic                                s_we_o,
  output logic [ext_device_pkg::ADDR_W-1:0]   s_addr_o,
  output logic [ext_device_pkg::DATA_W-1:0]   s_wdata_o,
  output logic [ext_device_pkg::BE_W-1:0]     s_be_o,
  input  logic                                s_gnt_i,
  input  logic                                s_rvalid_i,
  input  logic [ext_device_pkg::DATA_W-1:0]   s_rdata_i
);

  logic sel;
  logic prio_q;
  logic owner_q;

  // prio_q names the master that wins a tie
  assign sel = (m0_req_i & m1_req_i) ? prio_q : m1_req_i;

  assign s_req_o   = m0_req_i | m1_req_i;
  assign s_we_o    = sel ? m1_we_i : m0_we_i;
  assign s_addr_o  = sel ? m1_addr_i : m0_addr_i;
  assign s_wdata_o = sel ? m1_wdata_i : m0_wdata_i;
  assign s_be_o    = sel ? m1_be_i : m0_be_i;

  assign m0_gnt_o = s_gnt_i & m0_req_i & ~sel;
  assign m1_gnt_o = s_gnt_i & m1_req_i & sel;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prio_q  <= 1'b0;
      owner_q <= 1'b0;
    end else if (s_req_o && s_gnt_i) begin
      owner_q <= sel;
      prio_q  <= ~sel;
    end
  end

  // Response goes only to the master that holds the grant
  assign m0_rvalid_o = s_rvalid_i & ~owner_q;
  assign m1_rvalid_o = s_rvalid_i & owner_q;
  assign m0_rdata_o  = owner_q ? '0 : s_rdata_i;
  assign m1_rdata_o  = owner_q ? s_rdata_i : '0;

endmodule

/* hdl/slow_memory.sv */
// Word RAM with byte enables behind an OBI slave port
// Grant comes after 0 to 3 wait cycles picked by a free-running LFSR

`timescale 1ns/1ps

module slow_memory #(
  parameter int unsigned NUM_WORDS = 128
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                req_i,
  input  logic                                we_i,
  input  logic [$clog2(NUM_WORDS)-1:0]        addr_i,
  input  logic [ext_device_pkg::DATA_W-1:0]   wdata_i,
  input  logic [ext_device_pkg::BE_W-1:0]     be_i,
  output logic                                gnt_o,
  output logic                                rvalid_o,
  output logic [ext_device_pkg::DATA_W-1:0]   rdata_o
);

  logic [ext_device_pkg::DATA_W-1:0] mem [NUM_WORDS];

  logic [3:0] lfsr_q;
  logic       waiting_q;
  logic [1:0] wait_q;
  logic [1:0] cur_wait;
  logic       rvalid_q;
  logic [ext_device_pkg::DATA_W-1:0] rdata_q;

  // Delay is drawn once per request and then counted down
  assign cur_wait = waiting_q ? wait_q : lfsr_q[1:0];
  assign gnt_o    = req_i & (cur_wait == 2'd0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lfsr_q    <= 4'b1001;
      waiting_q <= 1'b0;
      wait_q    <= 2'd0;
      rvalid_q  <= 1'b0;
    end else begin
      // x^4 + x^3 + 1
      lfsr_q   <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
      rvalid_q <= gnt_o;
      if (gnt_o) begin
        waiting_q <= 1'b0;
      end else if (req_i) begin
        waiting_q <= 1'b1;
        wait_q    <= cur_wait - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      if (we_i) begin
        for (int b = 0; b < ext_device_pkg::BE_W; b++) begin
          if (be_i[b]) begin
            mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[addr_i];
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

/* tb.f */
hdl/ext_device_pkg.sv
hdl/memcopy_regs.sv
hdl/memcopy_engine.sv
hdl/obi_arbiter.sv
hdl/slow_memory.sv
hdl/gpio_cnt.sv
hdl/ext_device_top.sv
tests/tb_ext_device.sv

/* tests/ext_device_golden.txt */
# Columns: op arg1 arg2 arg3, all numbers hex. W addr data be, R addr exp, G reg data,
# Q reg exp err, B addr exp (background read), C src dst size, P pulses gpio, T name
Q 10 00000000 0
T reset_state
W 00000000 11223344 f
W 00000000 aabbccdd 5
W 00000004 cafef00d f
W 00000004 12345678 8
W 00000008 deadbeef f
W 00000008 00000000 6
R 00000000 11bb33dd
R 00000004 12fef00d
R 00000008 de0000ef
T byte_enables
G 00 00000040
G 04 00000080
G 08 00000004
Q 00 00000040 0
Q 04 00000080 0
Q 08 00000004 0
Q 14 00000000 1
Q 100 00000000 1
T register_port
W 00000040 01010101 f
W 00000044 02020202 f
W 00000048 03030303 f
W 0000004c 04040404 f
W 00000100 a0a0a0a0 f
W 00000104 b1b1b1b1 f
W 00000108 c2c2c2c2 f
W 0000010c d3d3d3d3 f
B 00000100 a0a0a0a0
B 00000104 b1b1b1b1
B 00000108 c2c2c2c2
B 0000010c d3d3d3d3
C 00000040 00000080 4
R 00000080 01010101
R 00000084 02020202
R 00000088 03030303
R 0000008c 04040404
R 00000040 01010101
R 0000004c 04040404
T copy_with_traffic
W 000000c0 5a5a5a5a f
C 00000040 000000c0 0
R 000000c0 5a5a5a5a
T copy_size_zero
P 8 1
P 7 1
P 1 0
T gpio_counter

/* tests/tb_ext_device.sv */
// Testbench for the external device subsystem
// Plays the golden file commands against the DUT and checks each response

`timescale 1ns/1ps

module tb_ext_device;

  localparam int unsigned TIMEOUT = 200;

  logic                                clk_i;
  logic                                rst_n_i;
  logic                                reg_req_i;
  logic                                reg_we_i;
  logic [ext_device_pkg::ADDR_W-1:0]   reg_addr_i;
  logic [ext_device_pkg::DATA_W-1:0]   reg_wdata_i;
  logic [ext_device_pkg::DATA_W-1:0]   reg_rdata_o;
  logic                                reg_ready_o;
  logic                                reg_error_o;
  logic                                ext_req_i;
  logic                                ext_we_i;
  logic [ext_device_pkg::ADDR_W-1:0]   ext_addr_i;
  logic [ext_device_pkg::DATA_W-1:0]   ext_wdata_i;
  logic [ext_device_pkg::BE_W-1:0]     ext_be_i;
  logic                                ext_gnt_o;
  logic                                ext_rvalid_o;
  logic [ext_device_pkg::DATA_W-1:0]   ext_rdata_o;
  logic                                memcopy_intr_o;
  logic                                gpio_i;
  logic                                gpio_o;

  int unsigned cycle_cnt;
  int unsigned err_cnt;
  int unsigned test_err_base;
  int unsigned pass_cnt;
  int unsigned fail_cnt;
  logic        timed_out;
  integer      seed;
  integer      fd;
  integer      code;
  logic        reading;
  logic [7:0]  op;
  logic [31:0] arg_a;
  logic [31:0] arg_b;
  logic [31:0] arg_c;
  logic [31:0] rd_val;
  logic        rd_err;
  logic [8*32-1:0]  test_name;
  logic [8*128-1:0] skip_buf;

  // Addresses and expected words for reads issued while a copy runs
  logic [31:0] bg_addr[$];
  logic [31:0] bg_exp[$];

  ext_device_top #(
    .NUM_WORDS (128),
    .CNT_MAX   (8)
  ) dut (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .reg_req_i      (reg_req_i),
    .reg_we_i       (reg_we_i),
    .reg_addr_i     (reg_addr_i),
    .reg_wdata_i    (reg_wdata_i),
    .reg_rdata_o    (reg_rdata_o),
    .reg_ready_o    (reg_ready_o),
    .reg_error_o    (reg_error_o),
    .ext_req_i      (ext_req_i),
    .ext_we_i       (ext_we_i),
    .ext_addr_i     (ext_addr_i),
    .ext_wdata_i    (ext_wdata_i),
    .ext_be_i       (ext_be_i),
    .ext_gnt_o      (ext_gnt_o),
    .ext_rvalid_o   (ext_rvalid_o),
    .ext_rdata_o    (ext_rdata_o),
    .memcopy_intr_o (memcopy_intr_o),
    .gpio_i         (gpio_i),
    .gpio_o         (gpio_o)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Inputs change 2 ns after the rising edge
  task next_cycle;
    @(posedge clk_i);
    #2;
  endtask

  task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR time %0t %s got %h expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task report_timeout(input string what);
    $display("Timeout at %0t: %s did not arrive within %0d cycles", $time, what, TIMEOUT);
    err_cnt++;
    timed_out = 1'b1;
  endtask

  task reg_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                  output logic [31:0] rdata, output logic err);
    reg_req_i   = 1'b1;
    reg_we_i    = we;
    reg_addr_i  = addr;
    reg_wdata_i = wdata;
    @(negedge clk_i);
    check_value("reg_ready_o", reg_ready_o, 32'd1);
    rdata = reg_rdata_o;
    err   = reg_error_o;
    next_cycle();
    reg_req_i = 1'b0;
    reg_we_i  = 1'b0;
  endtask

  task obi_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                  input logic [3:0] be, output logic [31:0] rdata);
    int unsigned waited;
    logic        granted;
    logic        answered;
    granted     = 1'b0;
    answered    = 1'b0;
    waited      = 0;
    rdata       = '0;
    ext_req_i   = 1'b1;
    ext_we_i    = we;
    ext_addr_i  = addr;
    ext_wdata_i = wdata;
    ext_be_i    = be;
    // Request is held until a grant is seen
    while (!granted && waited < TIMEOUT) begin
      @(negedge clk_i);
      granted = ext_gnt_o;
      next_cycle();
      waited++;
    end
    ext_req_i = 1'b0;
    ext_we_i  = 1'b0;
    if (!granted) begin
      report_timeout("ext_gnt_o");
    end else begin
      waited = 0;
      while (!answered && waited < TIMEOUT) begin
        @(negedge clk_i);
        if (ext_rvalid_o) begin
          answered = 1'b1;
          rdata    = ext_rdata_o;
        end
        next_cycle();
        waited++;
      end
      if (!answered) begin
        report_timeout("ext_rvalid_o");
      end
    end
  endtask

  task read_and_check(input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] rdata;
    obi_access(1'b0, addr, '0, 4'hf, rdata);
    if (!timed_out) begin
      check_value("ext_rdata_o", rdata, exp);
    end
  endtask

  task write_word(input logic [31:0] addr, input logic [31:0] data, input logic [3:0] be);
    logic [31:0] rdata;
    obi_access(1'b1, addr, data, be, rdata);
    // Write responses carry zero data
    if (!timed_out) begin
      check_value("ext_rdata_o", rdata, 32'd0);
    end
  endtask

  task run_copy(input logic [31:0] src, input logic [31:0] dst, input logic [31:0] size);
    logic [31:0] rdata;
    logic        err;
    logic        seen;
    int unsigned start_cycle;
    int unsigned idx;
    reg_access(1'b1, 32'(ext_device_pkg::REG_SRC), src, rdata, err);
    reg_access(1'b1, 32'(ext_device_pkg::REG_DST), dst, rdata, err);
    reg_access(1'b1, 32'(ext_device_pkg::REG_SIZE), size, rdata, err);
    reg_access(1'b1, 32'(ext_device_pkg::REG_START), 32'd0, rdata, err);
    // A copy of at least one word is still running a cycle later
    if (size != 0) begin
      next_cycle();
      reg_access(1'b0, 32'(ext_device_pkg::REG_STATUS), 32'd0, rdata, err);
      check_value("reg_rdata_o", rdata, 32'h2);
    end
    seen        = 1'b0;
    start_cycle = cycle_cnt;
    // Outside reads compete with the engine until the interrupt shows up
    while (!seen && !timed_out && (cycle_cnt - start_cycle) < TIMEOUT) begin
      if (bg_addr.size() != 0) begin
        idx = $unsigned($random(seed)) % bg_addr.size();
        read_and_check(bg_addr[idx], bg_exp[idx]);
      end
      @(negedge clk_i);
      seen = memcopy_intr_o;
      next_cycle();
    end
    if (!seen && !timed_out) begin
      report_timeout("memcopy_intr_o");
    end else if (seen) begin
      reg_access(1'b0, 32'(ext_device_pkg::REG_STATUS), 32'd0, rdata, err);
      check_value("reg_rdata_o", rdata, 32'h1);
      check_value("reg_error_o", err, 32'd0);
      @(negedge clk_i);
      check_value("memcopy_intr_o", memcopy_intr_o, 32'd0);
      next_cycle();
      reg_access(1'b0, 32'(ext_device_pkg::REG_STATUS), 32'd0, rdata, err);
      check_value("reg_rdata_o", rdata, 32'd0);
    end
  endtask

  task pulse_gpio(input int unsigned pulses, input logic exp);
    repeat (pulses) begin
      gpio_i = 1'b1;
      next_cycle();
      next_cycle();
      gpio_i = 1'b0;
      next_cycle();
      next_cycle();
    end
    // Let the synchronizer settle
    next_cycle();
    next_cycle();
    @(negedge clk_i);
    check_value("gpio_o", gpio_o, 32'(exp));
    next_cycle();
  endtask

  task close_test(input logic [8*32-1:0] name);
    if (err_cnt == test_err_base) begin
      pass_cnt++;
      $display("test %0s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %0s: %0d errors", name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  initial begin
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    reg_req_i     = 1'b0;
    reg_we_i      = 1'b0;
    reg_addr_i    = '0;
    reg_wdata_i   = '0;
    ext_req_i     = 1'b0;
    ext_we_i      = 1'b0;
    ext_addr_i    = '0;
    ext_wdata_i   = '0;
    ext_be_i      = '0;
    gpio_i        = 1'b0;
    cycle_cnt     = 0;
    err_cnt       = 0;
    test_err_base = 0;
    pass_cnt      = 0;
    fail_cnt      = 0;
    timed_out     = 1'b0;
    seed          = 59721;

    repeat (10) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_value("memcopy_intr_o", memcopy_intr_o, 32'd0);
    check_value("gpio_o", gpio_o, 32'd0);
    check_value("ext_gnt_o", ext_gnt_o, 32'd0);
    next_cycle();

    fd = $fopen("tests/ext_device_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file tests/ext_device_golden.txt");
      err_cnt++;
    end else begin
      reading = 1'b1;
      while (reading && !timed_out) begin
        code = $fscanf(fd, " %c", op);
        if (code != 1) begin
          reading = 1'b0;
        end else begin
          case (op)
            "W": begin
              code = $fscanf(fd, "%h %h %h", arg_a, arg_b, arg_c);
              write_word(arg_a, arg_b, arg_c[3:0]);
            end
            "R": begin
              code = $fscanf(fd, "%h %h", arg_a, arg_b);
              read_and_check(arg_a, arg_b);
            end
            "G": begin
              code = $fscanf(fd, "%h %h", arg_a, arg_b);
              reg_access(1'b1, arg_a, arg_b, rd_val, rd_err);
              check_value("reg_error_o", rd_err, 32'd0);
            end
            "Q": begin
              code = $fscanf(fd, "%h %h %h", arg_a, arg_b, arg_c);
              reg_access(1'b0, arg_a, 32'd0, rd_val, rd_err);
              check_value("reg_rdata_o", rd_val, arg_b);
              check_value("reg_error_o", rd_err, arg_c);
            end
            "B": begin
              code = $fscanf(fd, "%h %h", arg_a, arg_b);
              bg_addr.push_back(arg_a);
              bg_exp.push_back(arg_b);
            end
            "C": begin
              code = $fscanf(fd, "%h %h %h", arg_a, arg_b, arg_c);
              run_copy(arg_a, arg_b, arg_c);
            end
            "P": begin
              code = $fscanf(fd, "%h %h", arg_a, arg_b);
              pulse_gpio(arg_a, arg_b[0]);
            end
            "T": begin
              code = $fscanf(fd, "%s", test_name);
              close_test(test_name);
            end
            "#": begin
              code = $fgets(skip_buf, fd);
            end
            default: begin
              $display("Unknown command letter %c in the golden file", op);
              err_cnt++;
              code = $fgets(skip_buf, fd);
            end
          endcase
        end
      end
      $fclose(fd);
    end

    $display("tests passed %0d, tests failed %0d", pass_cnt, fail_cnt);
    if (err_cnt == 0 && fail_cnt == 0 && pass_cnt != 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
